// File: hdl/icache_pkg.sv
// shared types of the instruction cache, imported by every RTL block and the testbench
package icache_pkg;

    localparam int WORD_W      = 32;     // instruction word width
    localparam int LINE_WORDS  = 4;      // words per cache line
    localparam int LINE_ADDR_W = 28;     // byte address bits 31:4

    // fetch byte address split into its fields
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;  // selects the 16-byte line
        logic [1:0]             word_sel;   // word within the line
        logic [1:0]             byte_sel;   // ignored for fetches
    } fetch_req_t;

    // answer to one fetch
    typedef struct packed {
        logic [WORD_W-1:0] instr;  // addressed instruction word
        logic              hit;    // line was present when the fetch arrived
    } fetch_resp_t;

    // one tag entry of a way
    typedef struct packed {
        logic                   valid;
        logic [LINE_ADDR_W-1:0] line_addr;  // full line address, independent of set count
    } tag_entry_t;

    // one cache line, word 0 in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    // line request towards the second level
    typedef logic [LINE_ADDR_W-1:0] l2_req_t;

    // one word beat returned by the second level
    typedef logic [WORD_W-1:0] l2_beat_t;

    // cache controller states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        LOOKUP     = 3'd1,  // array read issued
        COMPARE    = 3'd2,  // tags checked against held address
        REFILL     = 3'd3,  // waiting for the line from the second level
        WRITE_LINE = 3'd4,  // victim way written
        REREAD     = 3'd5   // filled line read back to answer
    } ctrl_state_e;

    // way select, also the LRU encoding
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_e;

endpackage

// File: hdl/fetch_req_port.sv
// input side of the cache, captures a fetch strobe and holds its address until the answer
module fetch_req_port
    import icache_pkg::*;
#(
    parameter int SET_BITS = 8
) (
    input  logic                clk_tmp,
    input  logic                rst_n,
    input  logic                fetch_valid,   // one-cycle request strobe
    input  fetch_req_t          fetch_req,
    input  logic                done,          // controller finished the fetch
    output logic                start,         // one-cycle kick to the controller
    output fetch_req_t          held_addr,
    output logic [SET_BITS-1:0] set_index,
    output logic [1:0]          word_offset
);

    logic busy;    // a fetch is in flight
    logic accept;  // strobe taken this cycle

    // a strobe in the done cycle starts the next fetch directly
    assign accept = fetch_valid && (!busy || done);

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (accept) begin
            held_addr <= fetch_req;  // stays put for the whole fetch
        end
    end

    assign set_index   = held_addr.line_addr[SET_BITS-1:0];  // low line bits pick the set
    assign word_offset = held_addr.word_sel;

endmodule

// File: hdl/icache_ways.sv
// tag, data and LRU storage of the two cache ways, read one cycle after the index is given
module icache_ways
    import icache_pkg::*;
#(
    parameter int SET_BITS = 8
) (
    input  logic                clk_tmp,
    input  logic                rst_n,
    input  logic [SET_BITS-1:0] rd_index,
    input  logic [SET_BITS-1:0] wr_index,
    input  logic                wr_en0,
    input  logic                wr_en1,
    input  tag_entry_t          wr_tag,
    input  line_t               wr_line,
    input  logic                lru_wr,
    input  way_e                lru_way,
    output tag_entry_t          tag0,
    output tag_entry_t          tag1,
    output line_t               line0,
    output line_t               line1,
    output way_e                lru
);

    localparam int SETS = 1 << SET_BITS;

    logic [LINE_ADDR_W-1:0] tag_mem [2][SETS];  // line addresses per way
    line_t                  data_mem [2][SETS];
    logic [1:0][SETS-1:0]   valid_q;            // registers so reset clears in one cycle
    logic [SETS-1:0]        lru_q;              // 1 means way 1 is next victim

    logic [1:0]             wr_en;
    logic                   same_index;
    logic [LINE_ADDR_W-1:0] rd_addr [2];
    line_t                  rd_line [2];
    logic [1:0]             rd_valid;
    way_e                   rd_lru;

    assign wr_en      = {wr_en1, wr_en0};
    assign same_index = (wr_index == rd_index);  // write-first forwarding

    always_ff @(posedge clk_tmp) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index]  <= wr_tag.line_addr;
                data_mem[w][wr_index] <= wr_line;
            end
            if (wr_en[w] && same_index) begin
                rd_addr[w] <= wr_tag.line_addr;  // new line visible on the next cycle
                rd_line[w] <= wr_line;
            end else begin
                rd_addr[w] <= tag_mem[w][rd_index];
                rd_line[w] <= data_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            valid_q  <= '0;
            lru_q    <= '0;
            rd_valid <= '0;
            rd_lru   <= WAY0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    valid_q[w][wr_index] <= wr_tag.valid;
                end
                rd_valid[w] <= (wr_en[w] && same_index) ? wr_tag.valid : valid_q[w][rd_index];
            end
            if (lru_wr) begin
                lru_q[wr_index] <= (lru_way == WAY1);
            end
            rd_lru <= way_e'(lru_q[rd_index]);
        end
    end

    assign tag0.valid     = rd_valid[0];
    assign tag0.line_addr = rd_addr[0];
    assign tag1.valid     = rd_valid[1];
    assign tag1.line_addr = rd_addr[1];
    assign line0          = rd_line[0];
    assign line1          = rd_line[1];
    assign lru            = rd_lru;

endmodule

// File: hdl/icache_ctrl.sv
// cache controller FSM, handles lookup, hit answer, victim choice and the miss sequence
module icache_ctrl
    import icache_pkg::*;
#(
    parameter int SET_BITS = 8
) (
    input  logic                clk_tmp,
    input  logic                rst_n,
    input  logic                start,
    input  fetch_req_t          held_addr,
    input  logic [SET_BITS-1:0] set_index,
    input  logic [1:0]          word_offset,
    input  tag_entry_t          tag0,
    input  tag_entry_t          tag1,
    input  line_t               line0,
    input  line_t               line1,
    input  way_e                lru,
    output logic [SET_BITS-1:0] rd_index,
    output logic [SET_BITS-1:0] wr_index,
    output logic                wr_en0,
    output logic                wr_en1,
    output tag_entry_t          wr_tag,
    output line_t               wr_line,
    output logic                lru_wr,
    output way_e                lru_way,
    output logic                refill_start,
    output l2_req_t             refill_addr,
    input  logic                line_done,
    input  line_t               refill_line,
    output logic                done,
    output logic                resp_valid,
    output fetch_resp_t         fetch_resp
);

    ctrl_state_e state_q;
    way_e        victim_q;   // way chosen for the fill
    logic        missed_q;   // fetch missed on arrival

    logic        hit0;
    logic        hit1;
    logic        hit;
    way_e        hit_way;
    line_t       hit_line;
    logic [31:0] hit_word;
    way_e        victim;
    logic        answer;     // hit seen in a state that may respond

    always_comb begin
        hit0     = tag0.valid && (tag0.line_addr == held_addr.line_addr);
        hit1     = tag1.valid && (tag1.line_addr == held_addr.line_addr);
        hit      = hit0 || hit1;
        hit_way  = hit0 ? WAY0 : WAY1;
        hit_line = (hit_way == WAY0) ? line0 : line1;
        hit_word = hit_line[word_offset];
        // invalid way 0, then invalid way 1, else least recently used
        if (!tag0.valid) begin
            victim = WAY0;
        end else if (!tag1.valid) begin
            victim = WAY1;
        end else begin
            victim = lru;
        end
    end

    assign answer = hit && (state_q == COMPARE || state_q == REREAD);

    // the held index serves both read and write for the whole fetch
    assign rd_index = set_index;
    assign wr_index = set_index;

    assign wr_en0           = (state_q == WRITE_LINE) && (victim_q == WAY0);
    assign wr_en1           = (state_q == WRITE_LINE) && (victim_q == WAY1);
    assign wr_tag.valid     = 1'b1;
    assign wr_tag.line_addr = held_addr.line_addr;
    assign wr_line          = refill_line;

    assign lru_wr  = answer;
    assign lru_way = (hit_way == WAY0) ? WAY1 : WAY0;  // point at the way not used

    assign refill_start = (state_q == COMPARE) && !hit;
    assign refill_addr  = held_addr.line_addr;

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            victim_q   <= WAY0;
            missed_q   <= 1'b0;
            resp_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            done       <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        missed_q <= 1'b0;
                        state_q  <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state_q <= COMPARE;  // array outputs valid next cycle
                end
                COMPARE: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        done       <= 1'b1;
                        state_q    <= IDLE;
                    end else begin
                        victim_q <= victim;
                        missed_q <= 1'b1;
                        state_q  <= REFILL;
                    end
                end
                REFILL: begin
                    if (line_done) begin
                        state_q <= WRITE_LINE;
                    end
                end
                WRITE_LINE: begin
                    state_q <= REREAD;  // forwarded line shows up next cycle
                end
                REREAD: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        done       <= 1'b1;
                        state_q    <= IDLE;
                    end else begin
                        state_q <= LOOKUP;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (answer) begin
            fetch_resp.instr <= hit_word;
            fetch_resp.hit   <= !missed_q;  // a refilled line never counts as hit
        end
    end

endmodule

// File: hdl/l2_refill_port.sv
// output side of the cache, requests a line from the second level and gathers its four beats
module l2_refill_port
    import icache_pkg::*;
(
    input  logic     clk_tmp,
    input  logic     rst_n,
    input  logic     refill_start,   // one-cycle line request from the controller
    input  l2_req_t  refill_addr,
    output logic     l2_req_valid,
    output l2_req_t  l2_req,
    input  logic     l2_beat_valid,
    input  l2_beat_t l2_beat,
    output logic     line_done,      // one cycle after the fourth beat
    output line_t    refill_line
);

    logic       fill_active;  // request sent, beats still expected
    logic [1:0] beat_cnt;
    logic       take_beat;
    logic       last_beat;

    assign take_beat = fill_active && l2_beat_valid;
    assign last_beat = take_beat && (beat_cnt == 2'd3);

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            l2_req_valid <= 1'b0;
            fill_active  <= 1'b0;
            beat_cnt     <= 2'd0;
            line_done    <= 1'b0;
        end else begin
            l2_req_valid <= refill_start;
            line_done    <= last_beat;
            if (refill_start) begin
                fill_active <= 1'b1;
                beat_cnt    <= 2'd0;
            end else if (take_beat) begin
                beat_cnt <= beat_cnt + 2'd1;  // wraps to 0 after word 3
                if (last_beat) begin
                    fill_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (refill_start) begin
            l2_req <= refill_addr;
        end
    end

    // beats arrive in word order, so shifting down leaves word 0 in the low slot
    always_ff @(posedge clk_tmp) begin
        if (take_beat) begin
            refill_line <= {l2_beat, refill_line[3:1]};
        end
    end

endmodule

// File: hdl/icache_top.sv
// two-way instruction cache top level, sets the set count and wires the four blocks together
module icache_top
    import icache_pkg::*;
#(
    parameter int SET_BITS = 8
) (
    input  logic        clk_tmp,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  fetch_req_t  fetch_req,
    output logic        resp_valid,
    output fetch_resp_t fetch_resp,
    output logic        l2_req_valid,
    output l2_req_t     l2_req,
    input  logic        l2_beat_valid,
    input  l2_beat_t    l2_beat
);

    logic                start;
    logic                done;
    fetch_req_t          held_addr;
    logic [SET_BITS-1:0] set_index;
    logic [1:0]          word_offset;

    logic [SET_BITS-1:0] rd_index;
    logic [SET_BITS-1:0] wr_index;
    logic                wr_en0;
    logic                wr_en1;
    tag_entry_t          wr_tag;
    line_t               wr_line;
    logic                lru_wr;
    way_e                lru_way;
    tag_entry_t          tag0;
    tag_entry_t          tag1;
    line_t               line0;
    line_t               line1;
    way_e                lru;

    logic                refill_start;
    l2_req_t             refill_addr;
    logic                line_done;
    line_t               refill_line;

    fetch_req_port #(
        .SET_BITS (SET_BITS)
    ) i_fetch_req_port (
        .clk_tmp     (clk_tmp),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .done        (done),
        .start       (start),
        .held_addr   (held_addr),
        .set_index   (set_index),
        .word_offset (word_offset)
    );

    icache_ways #(
        .SET_BITS (SET_BITS)
    ) i_icache_ways (
        .clk_tmp  (clk_tmp),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .wr_index (wr_index),
        .wr_en0   (wr_en0),
        .wr_en1   (wr_en1),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line),
        .lru_wr   (lru_wr),
        .lru_way  (lru_way),
        .tag0     (tag0),
        .tag1     (tag1),
        .line0    (line0),
        .line1    (line1),
        .lru      (lru)
    );

    icache_ctrl #(
        .SET_BITS (SET_BITS)
    ) i_icache_ctrl (
        .clk_tmp      (clk_tmp),
        .rst_n        (rst_n),
        .start        (start),
        .held_addr    (held_addr),
        .set_index    (set_index),
        .word_offset  (word_offset),
        .tag0         (tag0),
        .tag1         (tag1),
        .line0        (line0),
        .line1        (line1),
        .lru          (lru),
        .rd_index     (rd_index),
        .wr_index     (wr_index),
        .wr_en0       (wr_en0),
        .wr_en1       (wr_en1),
        .wr_tag       (wr_tag),
        .wr_line      (wr_line),
        .lru_wr       (lru_wr),
        .lru_way      (lru_way),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .line_done    (line_done),
        .refill_line  (refill_line),
        .done         (done),
        .resp_valid   (resp_valid),
        .fetch_resp   (fetch_resp)
    );

    l2_refill_port i_l2_refill_port (
        .clk_tmp       (clk_tmp),
        .rst_n         (rst_n),
        .refill_start  (refill_start),
        .refill_addr   (refill_addr),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_beat_valid (l2_beat_valid),
        .l2_beat       (l2_beat),
        .line_done     (line_done),
        .refill_line   (refill_line)
    );

endmodule

// File: sim/icache_tb.sv
// testbench for the instruction cache, replays the stimulus file against a second-level memory model
module icache_tb
    import icache_pkg::*;
();

    logic        clk_tmp;
    logic        rst_n;
    logic        fetch_valid;
    fetch_req_t  fetch_req;
    logic        resp_valid;
    fetch_resp_t fetch_resp;
    logic        l2_req_valid;
    l2_req_t     l2_req;
    logic        l2_beat_valid;
    l2_beat_t    l2_beat;

    logic [31:0] addr_q [$];   // one entry per stimulus line
    fetch_resp_t exp_q [$];
    logic        busy_q [$];   // send a second strobe during this fetch
    integer      seed        = 60690;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    int          resp_cnt    = 0;
    int          l2_req_cnt  = 0;
    l2_req_t     last_l2_req;

    icache_top #(
        .SET_BITS (8)
    ) i_dut (
        .clk_tmp       (clk_tmp),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_req     (fetch_req),
        .resp_valid    (resp_valid),
        .fetch_resp    (fetch_resp),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_beat_valid (l2_beat_valid),
        .l2_beat       (l2_beat)
    );

    initial begin
        clk_tmp = 1'b0;
        forever #5 clk_tmp = ~clk_tmp;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp);
        if (got.instr !== exp.instr) begin
            abort_run($sformatf("[FAIL] fetch_resp.instr got %h expected %h", got.instr, exp.instr));
        end else if (got.hit !== exp.hit) begin
            abort_run($sformatf("[FAIL] fetch_resp.hit got %h expected %h", got.hit, exp.hit));
        end
    endtask

    task automatic check_l2_req(input l2_req_t got, input l2_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] l2_req got %h expected %h", got, exp));
        end
    endtask

    // cycle count for the timeout, strobe counts for the response and request checks
    always @(posedge clk_tmp) begin
        cycle_cnt = cycle_cnt + 1;
        if (rst_n && resp_valid) begin
            resp_cnt = resp_cnt + 1;
        end
        if (rst_n && l2_req_valid) begin
            l2_req_cnt  = l2_req_cnt + 1;
            last_l2_req = l2_req;
        end
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run("timeout: the fetches did not finish within the cycle limit");
        end
    end

    // second-level memory, four beats per line request
    initial begin
        int      gap;
        int      fill_cnt;
        l2_req_t line;
        fill_cnt      = 0;
        l2_beat_valid = 1'b0;
        l2_beat       = '0;
        forever begin
            @(negedge clk_tmp);
            if (rst_n && l2_req_valid) begin
                fill_cnt = fill_cnt + 1;
                line     = l2_req;
                for (int b = 0; b < 4; b++) begin
                    gap = (fill_cnt == 1) ? 0 : ($random(seed) & 3);  // first fill back-to-back
                    repeat (gap) @(negedge clk_tmp);
                    l2_beat_valid = 1'b1;
                    l2_beat       = {line, b[1:0], 2'b00} ^ 32'hC3A5_5A3C;
                    @(negedge clk_tmp);
                    l2_beat_valid = 1'b0;
                end
            end
        end
    end

    task automatic load_stimulus();
        int          fd;
        string       text;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] hit;
        logic [31:0] busy;
        fetch_resp_t exp;
        fd = $fopen("sim/icache_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file sim/icache_stimulus.txt");
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text.getc(0) != 8'h23) begin  // skip '#' lines and blanks
                if ($sscanf(text, "%h %h %h %h", addr, word, hit, busy) != 4) begin
                    abort_run({"malformed stimulus line: ", text});
                end
                exp.instr = word;
                exp.hit   = hit[0];
                addr_q.push_back(addr);
                exp_q.push_back(exp);
                busy_q.push_back(busy[0]);
            end
        end
        $fclose(fd);
    endtask

    // one fetch, entered and left on a falling edge
    task automatic run_fetch(input logic [31:0] addr, input fetch_resp_t exp, input logic busy);
        int resp_before;
        int l2_before;
        int lat;
        resp_before = resp_cnt;
        l2_before   = l2_req_cnt;
        fetch_valid = 1'b1;
        fetch_req   = fetch_req_t'(addr);
        @(posedge clk_tmp);                               // sampling edge
        @(negedge clk_tmp);
        fetch_valid = busy;                               // lands while the fetch is active
        fetch_req   = fetch_req_t'(addr ^ 32'h0001_0000);  // another line
        lat = 0;
        while (resp_valid !== 1'b1) begin
            @(negedge clk_tmp);
            fetch_valid = 1'b0;
            lat++;
        end
        check_resp(fetch_resp, exp);
        if (exp.hit && lat != 3) begin
            abort_run($sformatf("hit at %h answered after %0d cycles instead of 3", addr, lat));
        end
        repeat (busy ? 8 : 1) @(negedge clk_tmp);
        if (resp_cnt != resp_before + 1) begin
            abort_run($sformatf("fetch %h gave %0d responses", addr, resp_cnt - resp_before));
        end
        if (exp.hit) begin
            if (l2_req_cnt != l2_before) begin
                abort_run($sformatf("hit at %h sent a line request", addr));
            end
        end else begin
            if (l2_req_cnt != l2_before + 1) begin
                abort_run($sformatf("miss at %h did not send exactly one line request", addr));
            end
            check_l2_req(last_l2_req, addr[31:4]);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        load_stimulus();
        if (addr_q.size() == 0) begin
            abort_run("the stimulus file holds no fetches");
        end
        cycle_limit = addr_q.size() * 40 + 100;
        repeat (16) @(posedge clk_tmp);
        @(negedge clk_tmp);
        rst_n = 1'b1;
        @(negedge clk_tmp);
        if (resp_valid !== 1'b0 || l2_req_valid !== 1'b0) begin
            abort_run("response or line request strobe active right after reset");
        end
        for (int i = 0; i < addr_q.size(); i++) begin
            run_fetch(addr_q[i], exp_q[i], busy_q[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: sim/icache_stimulus.txt
# columns in hex: fetch address, expected word, expected hit flag, extra strobe while busy
# words follow the memory rule, byte address xor c3a55a3c
00000100 C3A55B3C 0 0
00000108 C3A55B34 1 0
0000010C C3A55B30 1 0
00000104 C3A55B38 1 0
00000A24 C3A55018 0 0
00000A2C C3A55010 1 0
00001040 C3A54A7C 0 0
00002044 C3A57A78 0 0
0000104C C3A54A70 1 0
00002048 C3A57A74 1 0
00001044 C3A54A78 1 0
00003040 C3A56A7C 0 0
00001048 C3A54A74 1 0
0000304C C3A56A70 1 0
00002040 C3A57A7C 0 0
00003044 C3A56A78 1 0
00005FFC C3A505C0 0 0
00005FF0 C3A505CC 1 0
80000010 43A55A2C 0 0
8000001C 43A55A20 1 0
00004000 C3A51A3C 0 1
00000100 C3A55B3C 1 1

// File: tb.f
hdl/icache_pkg.sv
hdl/fetch_req_port.sv
hdl/icache_ways.sv
hdl/icache_ctrl.sv
hdl/l2_refill_port.sv
hdl/icache_top.sv
sim/icache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it; exit status is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module icache_tb \
    -f tb.f \
    --Mdir obj_dir -o icache_sim

./obj_dir/icache_sim
